// ==== dv/errsig_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module errsig_assert
    import wb_bus_pkg::*;
(
    input wire           i_clk,
    input wire           i_rst_n,
    input wire           i_wr_cyc,     // Writer master
    input wire           i_wr_stb,
    input wire           i_wr_we,
    input wire wb_adr_t  i_wr_adr,
    input wire wb_dat_t  i_wr_dat,
    input wire           i_wr_ack,
    input wire           i_h_cyc,      // Host master
    input wire           i_h_stb,
    input wire           i_h_we,
    input wire wb_adr_t  i_h_adr,
    input wire wb_dat_t  i_h_dat,
    input wire           i_h_ack,
    input wire           i_s_cyc,      // Slave side of the arbiter
    input wire           i_s_stb,
    input wire           i_s_ack
);

    // ######################################################################
    // Wishbone classic handshake
    // ######################################################################

    a_wr_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wr_stb |-> i_wr_cyc) else $error("Writer stb without cyc");
    a_h_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_h_stb |-> i_h_cyc) else $error("Host stb without cyc");
    a_s_stb_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_s_stb |-> i_s_cyc) else $error("Slave stb without cyc");

    a_ack_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_s_ack |=> !i_s_ack) else $error("Slave ack longer than one cycle");
    a_ack_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_wr_ack && i_h_ack)) else $error("Writer and host acked together");

    // Request held until ack
    a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wr_stb && !i_wr_ack) |=> (i_wr_stb && $stable(i_wr_we) &&
        $stable(i_wr_adr) && $stable(i_wr_dat))) else $error("Writer request changed");
    a_h_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_h_stb && !i_h_ack) |=> (i_h_stb && $stable(i_h_we) &&
        $stable(i_h_adr) && $stable(i_h_dat))) else $error("Host request changed");

endmodule

`default_nettype wire

// ==== dv/errsig_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "errsig_defs.svh"

module errsig_tb
    import errsig_types_pkg::*;
    import wb_bus_pkg::*;
();

    localparam int DEPTH       = 1 << `ERRSIG_BUF_AW;
    localparam int BUS_TIMEOUT = 64;
    localparam int HALF_MARGIN = 72;    // 64 samples plus FSM overhead

    logic         clk;
    logic         rst_n;
    logic         status;
    logic         polarity;
    cycle_cnt_t   wait_cnt;
    err_word_t    offset_high;
    adc_sample_t  adc_data;
    avg_sel_t     avg_sel;
    err_word_t    err_th;
    logic         wbh_cyc;
    logic         wbh_stb;
    logic         wbh_we;
    wb_adr_t      wbh_adr;
    wb_dat_t      wbh_dat_w;
    wb_dat_t      wbh_dat_r;
    logic         wbh_ack;
    err_word_t    err_signal;
    logic         err_valid;
    wb_adr_t      wr_ptr;
    logic         overrun;

    wb_dat_t      exp_mem [DEPTH];   // Expected buffer contents
    wb_adr_t      exp_ptr;
    int           mismatch_cnt;
    int           timeout_cnt;

    errsig_top DUT (
        .i_clk(clk), .i_rst_n(rst_n), .i_status(status), .i_polarity(polarity),
        .i_wait_cnt(wait_cnt), .i_offset_high(offset_high), .i_adc_data(adc_data),
        .i_avg_sel(avg_sel), .i_err_th(err_th),
        .i_wbh_cyc(wbh_cyc), .i_wbh_stb(wbh_stb), .i_wbh_we(wbh_we), .i_wbh_adr(wbh_adr),
        .i_wbh_dat(wbh_dat_w), .o_wbh_dat(wbh_dat_r), .o_wbh_ack(wbh_ack),
        .o_err_signal(err_signal), .o_err_valid(err_valid), .o_wr_ptr(wr_ptr),
        .o_overrun(overrun)
    );

    bind errsig_top errsig_assert u_assert (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_wr_cyc(wr_cyc), .i_wr_stb(wr_stb), .i_wr_we(wr_we), .i_wr_adr(wr_adr),
        .i_wr_dat(wr_dat), .i_wr_ack(wr_ack),
        .i_h_cyc(i_wbh_cyc), .i_h_stb(i_wbh_stb), .i_h_we(i_wbh_we), .i_h_adr(i_wbh_adr),
        .i_h_dat(i_wbh_dat), .i_h_ack(o_wbh_ack),
        .i_s_cyc(s_cyc), .i_s_stb(s_stb), .i_s_ack(s_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ######################################################################
    // Compare tasks and reference model
    // ######################################################################

    task automatic check_err(input string name, input err_word_t got, input err_word_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input wb_dat_t got, input wb_dat_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("[ERROR] %0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_ptr(input string name, input wb_adr_t got, input wb_adr_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("[ERROR] %0t %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    // Average of a constant level is the level itself
    function automatic err_word_t expected_err(input adc_sample_t hi, input adc_sample_t lo,
                                               input err_word_t off, input logic pol);
        err_word_t avg_hi;
        err_word_t avg_lo;
        avg_hi = err_word_t'(hi) + off;
        avg_lo = err_word_t'(lo);
        return pol ? (avg_lo - avg_hi) : (avg_hi - avg_lo);
    endfunction

    function automatic err_word_t expected_gated(input err_word_t err, input err_word_t th);
        return ((err > th) || (err < -th)) ? err : '0;
    endfunction

    function automatic adc_sample_t rand_level();
        return adc_sample_t'($urandom);
    endfunction

    function automatic err_word_t rand_offset();
        return err_word_t'($urandom_range(0, 32'h1f_ffff)) - err_word_t'(32'h10_0000);
    endfunction

    // ######################################################################
    // Host bus and modulation drivers
    // ######################################################################

    task automatic host_transfer(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                                 output wb_dat_t rdat);
        int n;
        @(negedge clk);
        wbh_cyc   = 1'b1;
        wbh_stb   = 1'b1;
        wbh_we    = we;
        wbh_adr   = adr;
        wbh_dat_w = wdat;
        n = 0;
        @(negedge clk);
        while (!wbh_ack && n < BUS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        rdat = wbh_dat_r;
        if (!wbh_ack) begin
            timeout_cnt++;
            $display("Timeout: host access to word %0d was never acknowledged", adr);
        end
        @(negedge clk);   // Release in the cycle after ack
        wbh_cyc = 1'b0;
        wbh_stb = 1'b0;
        wbh_we  = 1'b0;
    endtask

    task automatic host_read(input wb_adr_t adr, output wb_dat_t rdat);
        host_transfer(1'b0, adr, '0, rdat);
    endtask

    task automatic host_write(input wb_adr_t adr, input wb_dat_t wdat);
        wb_dat_t unused;
        host_transfer(1'b1, adr, wdat, unused);
    endtask

    // High half for a fixed length, low half until the result shows up
    task automatic run_period(input adc_sample_t hi, input adc_sample_t lo);
        int n;
        int limit;
        limit = int'(wait_cnt) + HALF_MARGIN;
        @(negedge clk);
        status   = 1'b1;
        adc_data = hi;
        repeat (limit) @(negedge clk);
        status   = 1'b0;
        adc_data = lo;
        n = 0;
        while (!err_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!err_valid) begin
            timeout_cnt++;
            $display("Timeout: no error result after the low half of the period");
        end
    endtask

    task automatic wait_ptr(input wb_adr_t exp);
        int n;
        n = 0;
        while (wr_ptr !== exp && n < BUS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (wr_ptr !== exp) begin
            timeout_cnt++;
            $display("Timeout: write pointer stuck at %0d, waiting for %0d", wr_ptr, exp);
        end
    endtask

    task automatic measure(input adc_sample_t hi, input adc_sample_t lo, input logic read_prev);
        err_word_t exp;
        wb_adr_t   prev;
        wb_dat_t   rd;
        exp = expected_err(hi, lo, offset_high, polarity);
        run_period(hi, lo);
        check_err("o_err_signal", err_signal, exp);
        exp_mem[exp_ptr] = expected_gated(exp, err_th);
        prev    = exp_ptr - 1'b1;
        exp_ptr = exp_ptr + 1'b1;
        if (read_prev) begin
            host_read(prev, rd);   // Competes with the writer
            check_word($sformatf("buffer[%0d]", prev), rd, exp_mem[prev]);
        end
        wait_ptr(exp_ptr);
    endtask

    task automatic check_buffer();
        wb_adr_t adr;
        wb_dat_t rd;
        for (int i = 0; i < DEPTH; i++) begin
            adr = wb_adr_t'(i);
            host_read(adr, rd);
            check_word($sformatf("buffer[%0d]", i), rd, exp_mem[adr]);
        end
    endtask

    // ######################################################################
    // Directed tests
    // ######################################################################

    task automatic check_after_reset();
        check_flag("o_err_valid", err_valid, 1'b0);
        check_flag("o_overrun", overrun, 1'b0);
        check_ptr("o_wr_ptr", wr_ptr, '0);
        check_buffer();
    endtask

    task automatic measure_normal_polarity();
        polarity    = 1'b0;
        err_th      = '0;
        offset_high = rand_offset();
        avg_sel     = 3'd0;
        measure(rand_level(), rand_level(), 1'b0);
        avg_sel = 3'd3;
        measure(rand_level(), rand_level(), 1'b0);
        avg_sel = 3'd6;
        measure(rand_level(), rand_level(), 1'b0);
        check_buffer();
    endtask

    task automatic measure_inverted_polarity();
        polarity = 1'b1;
        avg_sel  = 3'd2;
        measure(rand_level(), rand_level(), 1'b0);
        avg_sel = 3'd7;   // Treated as 64 samples
        measure(rand_level(), rand_level(), 1'b0);
    endtask

    task automatic measure_dead_band();
        polarity    = 1'b0;
        offset_high = '0;
        err_th      = 32'sd100;
        avg_sel     = 3'd1;
        measure(14'sd500, 14'sd450, 1'b0);
        measure(14'sd100, 14'sd0, 1'b0);     // Equal to threshold
        measure(-14'sd300, 14'sd300, 1'b0);
        check_buffer();
    endtask

    task automatic fill_and_wrap();
        polarity    = 1'b0;
        err_th      = '0;
        wait_cnt    = 32'd4;
        offset_high = rand_offset();
        repeat (18) measure(rand_level(), rand_level(), 1'b1);
        check_buffer();
        check_flag("o_overrun", overrun, 1'b0);
    endtask

    task automatic write_then_read();
        wb_dat_t wd;
        wb_dat_t rd;
        wd = wb_dat_t'($urandom);
        host_write(4'd9, wd);
        exp_mem[9] = wd;
        host_read(4'd9, rd);
        check_word("buffer[9]", rd, wd);
        check_ptr("o_wr_ptr", wr_ptr, exp_ptr);
    endtask

    initial begin
        void'($urandom(32'h888d));
        rst_n        = 1'b0;
        status       = 1'b0;
        polarity     = 1'b0;
        wait_cnt     = 32'd10;
        offset_high  = '0;
        adc_data     = '0;
        avg_sel      = '0;
        err_th       = '0;
        wbh_cyc      = 1'b0;
        wbh_stb      = 1'b0;
        wbh_we       = 1'b0;
        wbh_adr      = '0;
        wbh_dat_w    = '0;
        exp_mem      = '{default: '0};
        exp_ptr      = '0;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        check_after_reset();
        measure_normal_polarity();
        measure_inverted_polarity();
        measure_dead_band();
        fill_and_wrap();
        write_then_read();

        $display("Checks done with %0d mismatches and %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hw/errsig_types_pkg.sv
hw/wb_bus_pkg.sv
hw/modulation_sampler.sv
hw/err_result_writer.sv
hw/wb_arbiter.sv
hw/err_buffer_ram.sv
hw/errsig_top.sv
dv/errsig_assert.sv
dv/errsig_tb.sv

// ==== hw/err_buffer_ram.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "errsig_defs.svh"

module err_buffer_ram
    import wb_bus_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire           i_wb_cyc,
    input  wire           i_wb_stb,
    input  wire           i_wb_we,
    input  wire wb_adr_t  i_wb_adr,
    input  wire wb_dat_t  i_wb_dat,
    output wb_dat_t       o_wb_dat,
    output logic          o_wb_ack
);

    localparam int DEPTH = 1 << `ERRSIG_BUF_AW;

    wb_dat_t mem [DEPTH];
    logic    req;

    // New request only while ack is not already out
    assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_wb_ack <= 1'b0;
        else
            o_wb_ack <= req;
    end

    // Write lands at the end of the ack cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end else if (o_wb_ack && i_wb_cyc && i_wb_we) begin
            mem[i_wb_adr] <= i_wb_dat;
        end
    end

    always_ff @(posedge i_clk) begin
        if (req)
            o_wb_dat <= mem[i_wb_adr];   // Valid together with ack
    end

endmodule

`default_nettype wire

// ==== hw/err_result_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module err_result_writer
    import errsig_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_err_valid,
    input  wire err_word_t  i_err_gated,
    input  wire             i_wb_ack,
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output logic            o_wb_we,
    output wb_adr_t         o_wb_adr,
    output wb_dat_t         o_wb_dat,
    output wb_adr_t         o_wr_ptr,
    output logic            o_overrun
);

    logic     pend_valid;
    wb_dat_t  pend_dat;
    logic     start_bus;
    wb_dat_t  start_dat;

    // A new cycle only begins from idle, pending word first
    assign start_bus = !o_wb_cyc && (pend_valid || i_err_valid);
    assign start_dat = pend_valid ? pend_dat : wb_dat_t'(i_err_gated);

    assign o_wb_we = 1'b1;   // Write-only master

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_cyc   <= 1'b0;
            o_wb_stb   <= 1'b0;
            o_wr_ptr   <= '0;
            pend_valid <= 1'b0;
            o_overrun  <= 1'b0;
        end else if (o_wb_cyc) begin
            if (i_wb_ack) begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wr_ptr <= o_wr_ptr + 1'b1;   // Wraps at 16
            end
            if (i_err_valid) begin
                pend_valid <= 1'b1;
                if (pend_valid)
                    o_overrun <= 1'b1;         // Older result lost
            end
        end else if (start_bus) begin
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
            if (pend_valid)
                pend_valid <= i_err_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_bus) begin
            o_wb_adr <= o_wr_ptr;
            o_wb_dat <= start_dat;
        end
        if (i_err_valid && (o_wb_cyc || pend_valid))
            pend_dat <= wb_dat_t'(i_err_gated);
    end

endmodule

`default_nettype wire

// ==== hw/errsig_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module errsig_top
    import errsig_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_status,
    input  wire               i_polarity,
    input  wire cycle_cnt_t   i_wait_cnt,
    input  wire err_word_t    i_offset_high,
    input  wire adc_sample_t  i_adc_data,
    input  wire avg_sel_t     i_avg_sel,
    input  wire err_word_t    i_err_th,
    input  wire               i_wbh_cyc,      // Host port
    input  wire               i_wbh_stb,
    input  wire               i_wbh_we,
    input  wire wb_adr_t      i_wbh_adr,
    input  wire wb_dat_t      i_wbh_dat,
    output wb_dat_t           o_wbh_dat,
    output logic              o_wbh_ack,
    output err_word_t         o_err_signal,
    output logic              o_err_valid,
    output wb_adr_t           o_wr_ptr,
    output logic              o_overrun
);

    err_word_t err_gated;

    logic      wr_cyc, wr_stb, wr_we, wr_ack;
    wb_adr_t   wr_adr;
    wb_dat_t   wr_dat;

    logic      s_cyc, s_stb, s_we, s_ack;
    wb_adr_t   s_adr;
    wb_dat_t   s_dat_w, s_dat_r;

    modulation_sampler u_sampler (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_status(i_status), .i_polarity(i_polarity),
        .i_wait_cnt(i_wait_cnt), .i_offset_high(i_offset_high), .i_adc_data(i_adc_data),
        .i_avg_sel(i_avg_sel), .i_err_th(i_err_th), .o_err_signal(o_err_signal),
        .o_err_gated(err_gated), .o_err_valid(o_err_valid)
    );

    err_result_writer u_writer (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_err_valid(o_err_valid),
        .i_err_gated(err_gated), .i_wb_ack(wr_ack), .o_wb_cyc(wr_cyc), .o_wb_stb(wr_stb),
        .o_wb_we(wr_we), .o_wb_adr(wr_adr), .o_wb_dat(wr_dat), .o_wr_ptr(o_wr_ptr),
        .o_overrun(o_overrun)
    );

    // Writer on m0 wins ties
    wb_arbiter u_arbiter (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_m0_cyc(wr_cyc), .i_m0_stb(wr_stb), .i_m0_we(wr_we), .i_m0_adr(wr_adr),
        .i_m0_dat(wr_dat),
        .i_m1_cyc(i_wbh_cyc), .i_m1_stb(i_wbh_stb), .i_m1_we(i_wbh_we),
        .i_m1_adr(i_wbh_adr), .i_m1_dat(i_wbh_dat),
        .i_s_ack(s_ack), .i_s_dat(s_dat_r), .o_m0_ack(wr_ack), .o_m1_ack(o_wbh_ack),
        .o_m1_dat(o_wbh_dat), .o_s_cyc(s_cyc), .o_s_stb(s_stb), .o_s_we(s_we),
        .o_s_adr(s_adr), .o_s_dat(s_dat_w)
    );

    err_buffer_ram u_ram (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wb_cyc(s_cyc), .i_wb_stb(s_stb),
        .i_wb_we(s_we), .i_wb_adr(s_adr), .i_wb_dat(s_dat_w), .o_wb_dat(s_dat_r),
        .o_wb_ack(s_ack)
    );

endmodule

`default_nettype wire

// ==== hw/errsig_types_pkg.sv ====
`default_nettype none
`include "errsig_defs.svh"

package errsig_types_pkg;

    typedef logic signed [`ERRSIG_ADC_W-1:0]  adc_sample_t;
    typedef logic signed [`ERRSIG_DATA_W-1:0] err_word_t;   // Offset, averages, error
    typedef logic [`ERRSIG_AVG_W-1:0]         avg_sel_t;    // log2 of sample count
    typedef logic [31:0]                      cycle_cnt_t;

    // One pass through the FSM covers one modulation period
    typedef enum logic [2:0] {
        WAIT_HIGH,
        SETTLE_HIGH,
        ACQ_HIGH,
        WAIT_LOW,
        SETTLE_LOW,
        ACQ_LOW,
        FORM_ERR,
        REPORT
    } sampler_state_t;

endpackage

`default_nettype wire

// ==== hw/modulation_sampler.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "errsig_defs.svh"

module modulation_sampler
    import errsig_types_pkg::*;
(
    input  wire               i_clk,
    input  wire               i_rst_n,
    input  wire               i_status,      // Modulation level
    input  wire               i_polarity,
    input  wire cycle_cnt_t   i_wait_cnt,
    input  wire err_word_t    i_offset_high,
    input  wire adc_sample_t  i_adc_data,
    input  wire avg_sel_t     i_avg_sel,
    input  wire err_word_t    i_err_th,
    output err_word_t         o_err_signal,
    output err_word_t         o_err_gated,
    output logic              o_err_valid
);

    sampler_state_t state_q;
    sampler_state_t state_d;

    cycle_cnt_t     settle_cnt;
    logic [6:0]     acq_cnt;         // Up to 64 samples
    logic [6:0]     n_samples;
    avg_sel_t       shift;

    err_word_t      adc_ext;
    err_word_t      sum;
    err_word_t      avg_high;
    err_word_t      avg_low;
    err_word_t      err_th_neg;

    // Select 7 falls back to 64 samples
    assign shift     = (i_avg_sel > avg_sel_t'(6)) ? avg_sel_t'(6) : i_avg_sel;
    assign n_samples = 7'd1 << shift;

    assign adc_ext = {{(`ERRSIG_DATA_W-`ERRSIG_ADC_W){i_adc_data[`ERRSIG_ADC_W-1]}},
                      i_adc_data};

    // ######################################################################
    // Period FSM
    // ######################################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT_HIGH:   if (i_status) state_d = SETTLE_HIGH;
            SETTLE_HIGH: if (settle_cnt == '0) state_d = ACQ_HIGH;
            ACQ_HIGH:    if (acq_cnt == '0) state_d = WAIT_LOW;
            WAIT_LOW:    if (!i_status) state_d = SETTLE_LOW;
            SETTLE_LOW:  if (settle_cnt == '0) state_d = ACQ_LOW;
            ACQ_LOW:     if (acq_cnt == '0) state_d = FORM_ERR;
            FORM_ERR:    state_d = REPORT;
            REPORT:      state_d = WAIT_HIGH;
            default:     state_d = WAIT_HIGH;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q    <= WAIT_HIGH;
            settle_cnt <= '0;
            acq_cnt    <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                WAIT_HIGH, WAIT_LOW: begin
                    settle_cnt <= i_wait_cnt;   // Config sampled per half
                    acq_cnt    <= n_samples;
                end
                SETTLE_HIGH, SETTLE_LOW: begin
                    if (settle_cnt != '0)
                        settle_cnt <= settle_cnt - 1'b1;
                end
                ACQ_HIGH, ACQ_LOW: begin
                    if (acq_cnt != '0)
                        acq_cnt <= acq_cnt - 1'b1;
                end
                default: ;
            endcase
        end
    end

    // ######################################################################
    // Accumulate, average, form error
    // ######################################################################

    // One accumulator serves both halves
    always_ff @(posedge i_clk) begin
        case (state_q)
            WAIT_HIGH, WAIT_LOW: sum <= '0;
            ACQ_HIGH: begin
                if (acq_cnt != '0)
                    sum <= sum + adc_ext;
                else
                    avg_high <= (sum >>> shift) + i_offset_high;
            end
            ACQ_LOW: begin
                if (acq_cnt != '0)
                    sum <= sum + adc_ext;
                else
                    avg_low <= sum >>> shift;
            end
            FORM_ERR: begin
                if (!i_polarity)
                    o_err_signal <= avg_high - avg_low;
                else
                    o_err_signal <= avg_low - avg_high;
            end
            default: ;
        endcase
    end

    assign err_th_neg = -i_err_th;

    // Dead band around zero
    assign o_err_gated = ((o_err_signal > i_err_th) || (o_err_signal < err_th_neg)) ?
                         o_err_signal : '0;

    assign o_err_valid = (state_q == REPORT);

endmodule

`default_nettype wire

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter
    import wb_bus_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire           i_m0_cyc,    // Writer
    input  wire           i_m0_stb,
    input  wire           i_m0_we,
    input  wire wb_adr_t  i_m0_adr,
    input  wire wb_dat_t  i_m0_dat,
    input  wire           i_m1_cyc,    // Host
    input  wire           i_m1_stb,
    input  wire           i_m1_we,
    input  wire wb_adr_t  i_m1_adr,
    input  wire wb_dat_t  i_m1_dat,
    input  wire           i_s_ack,
    input  wire wb_dat_t  i_s_dat,
    output logic          o_m0_ack,
    output logic          o_m1_ack,
    output wb_dat_t       o_m1_dat,
    output logic          o_s_cyc,
    output logic          o_s_stb,
    output logic          o_s_we,
    output wb_adr_t       o_s_adr,
    output wb_dat_t       o_s_dat
);

    wb_grant_t grant_q;
    wb_grant_t grant_d;

    // Re-arbitrate only once the owner has let go of cyc
    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            GRANT_WRITER: if (!i_m0_cyc) grant_d = i_m1_cyc ? GRANT_HOST : GRANT_NONE;
            GRANT_HOST:   if (!i_m1_cyc) grant_d = i_m0_cyc ? GRANT_WRITER : GRANT_NONE;
            default: begin
                if (i_m0_cyc)
                    grant_d = GRANT_WRITER;
                else if (i_m1_cyc)
                    grant_d = GRANT_HOST;
                else
                    grant_d = GRANT_NONE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            grant_q <= GRANT_NONE;
        else
            grant_q <= grant_d;
    end

    always_comb begin
        o_s_cyc = 1'b0;
        o_s_stb = 1'b0;
        o_s_we  = 1'b0;
        o_s_adr = '0;
        o_s_dat = '0;
        case (grant_q)
            GRANT_WRITER: begin
                o_s_cyc = i_m0_cyc;
                o_s_stb = i_m0_stb;
                o_s_we  = i_m0_we;
                o_s_adr = i_m0_adr;
                o_s_dat = i_m0_dat;
            end
            GRANT_HOST: begin
                o_s_cyc = i_m1_cyc;
                o_s_stb = i_m1_stb;
                o_s_we  = i_m1_we;
                o_s_adr = i_m1_adr;
                o_s_dat = i_m1_dat;
            end
            default: ;
        endcase
    end

    assign o_m0_ack = i_s_ack && (grant_q == GRANT_WRITER);
    assign o_m1_ack = i_s_ack && (grant_q == GRANT_HOST);
    assign o_m1_dat = i_s_dat;

endmodule

`default_nettype wire

// ==== hw/wb_bus_pkg.sv ====
`default_nettype none
`include "errsig_defs.svh"

package wb_bus_pkg;

    typedef logic [`ERRSIG_BUF_AW-1:0] wb_adr_t;   // Word address
    typedef logic [`ERRSIG_DATA_W-1:0] wb_dat_t;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_WRITER,   // Internal result writer, higher priority
        GRANT_HOST
    } wb_grant_t;

endpackage

`default_nettype wire

// ==== include/errsig_defs.svh ====
`ifndef ERRSIG_DEFS_SVH
`define ERRSIG_DEFS_SVH

// ##########################################################################
// Widths shared by the signal path and the result bus
// ##########################################################################

`define ERRSIG_ADC_W   14   // Raw ADC sample
`define ERRSIG_DATA_W  32   // Sums, errors, bus data

// Result buffer holds 2**ERRSIG_BUF_AW words
`define ERRSIG_BUF_AW  4
`define ERRSIG_AVG_W   3    // Select for 1..64 samples

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the error-signal testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module errsig_tb -f flist.f -o errsig_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/errsig_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF "=== PASS ==="; then
    exit 0
fi
exit 1
